//--- core_types_pkg.sv
`default_nettype none

package core_types_pkg;

	// --------------------
	// address widths
	localparam int VA_WIDTH = 32;
	localparam int PA_WIDTH = 16;
	localparam int PAGE_OFFSET_WIDTH = 12;
	localparam int VPN_WIDTH = VA_WIDTH - PAGE_OFFSET_WIDTH;
	localparam int PPN_WIDTH = PA_WIDTH - PAGE_OFFSET_WIDTH;
	localparam int WORD_WIDTH = 32;

	// --------------------
	// fetch blocks and cache lines share one size
	localparam int FETCH_BYTES = 16;
	localparam int FETCH_PARCELS = FETCH_BYTES / 2;
	localparam int LINE_WORDS = FETCH_BYTES / 4;

	// --------------------
	// single-level page table, one word per entry
	localparam logic [PA_WIDTH-1:0] PT_BASE = 16'hff00;
	localparam int PT_INDEX_WIDTH = 6;
	localparam int PTE_VALID_BIT = 31;
	// ppn sits in the low PPN_WIDTH bits of an entry

endpackage

`default_nettype wire

//--- fetch_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_model import core_types_pkg::*; #(
	parameter logic [31:0] SEED = 32'h1
) (
	input wire CLK,
	input wire req_valid,
	input wire [PA_WIDTH-1:0] req_addr,
	output logic resp_valid,
	output logic [WORD_WIDTH-1:0] resp_data
);

	integer seed;
	logic busy;
	logic [PA_WIDTH-1:0] addr;
	logic [31:0] r;
	int wait_left;

	// page table window first, pattern data everywhere else
	function automatic logic [WORD_WIDTH-1:0] word_at(input logic [PA_WIDTH-1:0] pa);
		logic [PA_WIDTH-1:0] v;
		if (pa >= PT_BASE) begin
			v = (pa - PT_BASE) >> 2;
			if (v < 16'd48) begin
				return (32'h1 << PTE_VALID_BIT) | 32'(v[PPN_WIDTH-1:0]);
			end
			return '0;
		end
		return 32'(pa) * 32'h9e37_79b9;
	endfunction

	initial begin
		seed = SEED;
		busy = 1'b0;
		addr = '0;
		wait_left = 0;
		resp_valid = 1'b0;
		resp_data = '0;
		forever begin
			@(posedge CLK);
			#1;
			resp_valid = 1'b0;
			if (busy) begin
				if (wait_left == 0) begin
					resp_valid = 1'b1;
					resp_data = word_at(addr);
					busy = 1'b0;
				end else begin
					wait_left = wait_left - 1;
				end
			end
			// answer 1 to 8 cycles after the request
			if (req_valid) begin
				busy = 1'b1;
				addr = req_addr;
				r = $random(seed);
				wait_left = int'(r % 32'd8);
			end
		end
	end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import core_types_pkg::*; #(
	parameter int ICACHE_SETS = 16
) (
	input wire CLK,
	input wire nRST,

	// restart and stall
	input wire restart_valid,
	input wire [VA_WIDTH-1:0] restart_pc,
	input wire istream_stall,

	// itlb
	output logic itlb_req_valid,
	output logic [VPN_WIDTH-1:0] itlb_req_vpn,
	input wire itlb_resp_valid,
	input wire itlb_resp_miss,
	input wire [PPN_WIDTH-1:0] itlb_resp_ppn,
	input wire itlb_resp_page_fault,

	// icache
	output logic icache_req_valid,
	output logic [$clog2(ICACHE_SETS)-1:0] icache_req_index,
	input wire icache_resp_valid,
	input wire [PA_WIDTH-$clog2(ICACHE_SETS)-$clog2(FETCH_BYTES)-1:0] icache_resp_tag,
	input wire [LINE_WORDS-1:0][WORD_WIDTH-1:0] icache_resp_data,
	output logic icache_resp_hit,
	output logic icache_resp_miss_valid,
	output logic [PA_WIDTH-$clog2(ICACHE_SETS)-$clog2(FETCH_BYTES)-1:0] icache_resp_miss_tag,

	// instruction stream
	output logic istream_valid,
	output logic [VA_WIDTH-1:0] istream_pc,
	output logic [FETCH_PARCELS-1:0][15:0] istream_instr,
	output logic istream_page_fault
);

	localparam int OFFSET_W = $clog2(FETCH_BYTES);
	localparam int INDEX_W = $clog2(ICACHE_SETS);
	localparam int TAG_W = PA_WIDTH - INDEX_W - OFFSET_W;

	logic active;
	logic [VA_WIDTH-1:0] pc;
	logic cmp_valid;
	logic [VA_WIDTH-1:0] cmp_pc;
	logic [PA_WIDTH-1:0] cmp_pa;
	logic tlb_hit;
	logic tlb_fault;
	logic tag_match;
	logic deliver;
	logic fault_out;
	logic replay;
	logic issue;

	// --------------------
	// compare stage
	assign cmp_pa = {itlb_resp_ppn, cmp_pc[PAGE_OFFSET_WIDTH-1:0]};
	assign icache_resp_miss_tag = cmp_pa[PA_WIDTH-1 -: TAG_W];

	// a response flagged as miss carries no translation
	assign tlb_hit = cmp_valid & itlb_resp_valid & ~itlb_resp_miss & ~itlb_resp_page_fault;
	assign tlb_fault = cmp_valid & itlb_resp_valid & itlb_resp_page_fault;
	assign tag_match = icache_resp_valid && (icache_resp_tag == icache_resp_miss_tag);

	assign deliver = ~restart_valid & ~istream_stall & (tlb_fault | (tlb_hit & tag_match));
	assign fault_out = deliver & tlb_fault;
	// anything in compare that does not leave goes round again
	assign replay = cmp_valid & ~restart_valid & ~deliver;

	assign icache_resp_hit = ~restart_valid & tlb_hit & tag_match;
	assign icache_resp_miss_valid = ~restart_valid & tlb_hit & ~tag_match;

	assign istream_valid = deliver;
	assign istream_pc = cmp_pc;
	assign istream_page_fault = tlb_fault;
	assign istream_instr = tlb_fault ? '0 : icache_resp_data;

	// --------------------
	// lookup stage
	assign issue = active & ~restart_valid & ~replay & ~fault_out;

	assign itlb_req_valid = issue;
	assign itlb_req_vpn = pc[VA_WIDTH-1 -: VPN_WIDTH];
	assign icache_req_valid = issue;
	assign icache_req_index = pc[OFFSET_W +: INDEX_W];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			active <= 1'b0;
			cmp_valid <= 1'b0;
			pc <= '0;
			cmp_pc <= '0;
		end else if (restart_valid) begin
			// flush both stages
			active <= 1'b1;
			cmp_valid <= 1'b0;
			pc <= {restart_pc[VA_WIDTH-1:OFFSET_W], {OFFSET_W{1'b0}}};
		end else if (fault_out) begin
			// wait here for the next restart
			active <= 1'b0;
			cmp_valid <= 1'b0;
		end else if (replay) begin
			cmp_valid <= 1'b0;
			pc <= cmp_pc;
		end else begin
			cmp_valid <= issue;
			if (issue) begin
				cmp_pc <= pc;
				pc <= pc + VA_WIDTH'(FETCH_BYTES);
			end
		end
	end

endmodule

`default_nettype wire

//--- fetch_unit_wrapper.f
core_types_pkg.sv
fetch_unit.sv
itlb.sv
icache.sv
mem_arbiter.sv
fetch_unit_wrapper.sv
fetch_mem_model.sv
tb_fetch_unit_wrapper.sv

//--- fetch_unit_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit_wrapper import core_types_pkg::*; #(
	parameter int ITLB_ENTRIES = 4,
	parameter int ICACHE_SETS = 16
) (
	input wire CLK,
	input wire nRST,

	// back end
	input wire next_restart_valid,
	input wire [VA_WIDTH-1:0] next_restart_pc,
	input wire next_istream_stall,
	output logic last_istream_valid,
	output logic [VA_WIDTH-1:0] last_istream_pc,
	output logic [FETCH_PARCELS-1:0][15:0] last_istream_instr,
	output logic last_istream_page_fault,

	// backing memory
	output logic last_mem_req_valid,
	output logic [PA_WIDTH-1:0] last_mem_req_addr,
	input wire next_mem_resp_valid,
	input wire [WORD_WIDTH-1:0] next_mem_resp_data
);

	localparam int OFFSET_W = $clog2(FETCH_BYTES);
	localparam int INDEX_W = $clog2(ICACHE_SETS);
	localparam int TAG_W = PA_WIDTH - INDEX_W - OFFSET_W;

	// --------------------
	// internal connections
	logic restart_valid;
	logic [VA_WIDTH-1:0] restart_pc;
	logic istream_stall;
	logic istream_valid;
	logic [VA_WIDTH-1:0] istream_pc;
	logic [FETCH_PARCELS-1:0][15:0] istream_instr;
	logic istream_page_fault;

	logic itlb_req_valid;
	logic [VPN_WIDTH-1:0] itlb_req_vpn;
	logic itlb_resp_valid;
	logic itlb_resp_miss;
	logic [PPN_WIDTH-1:0] itlb_resp_ppn;
	logic itlb_resp_page_fault;

	logic icache_req_valid;
	logic [INDEX_W-1:0] icache_req_index;
	logic icache_resp_valid;
	logic [TAG_W-1:0] icache_resp_tag;
	logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] icache_resp_data;
	logic icache_resp_hit;
	logic icache_resp_miss_valid;
	logic [TAG_W-1:0] icache_resp_miss_tag;

	logic walk_req_valid;
	logic [PA_WIDTH-1:0] walk_req_addr;
	logic walk_resp_valid;
	logic refill_req_valid;
	logic [PA_WIDTH-1:0] refill_req_addr;
	logic refill_resp_valid;
	logic [WORD_WIDTH-1:0] resp_data;
	logic mem_req_valid;
	logic [PA_WIDTH-1:0] mem_req_addr;
	logic mem_resp_valid;
	logic [WORD_WIDTH-1:0] mem_resp_data;

	// --------------------
	// fetch pipeline
	fetch_unit #(.ICACHE_SETS(ICACHE_SETS)) u_fetch_unit (.*);
	itlb #(.ITLB_ENTRIES(ITLB_ENTRIES)) u_itlb (.*, .walk_resp_data(resp_data));
	icache #(.ICACHE_SETS(ICACHE_SETS)) u_icache (.*, .refill_resp_data(resp_data));
	mem_arbiter u_mem_arbiter (.*);

	// --------------------
	// boundary registers
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			restart_valid <= 1'b0;
			restart_pc <= '0;
			istream_stall <= 1'b0;
			mem_resp_valid <= 1'b0;
			mem_resp_data <= '0;
			last_istream_valid <= 1'b0;
			last_istream_pc <= '0;
			last_istream_instr <= '0;
			last_istream_page_fault <= 1'b0;
			last_mem_req_valid <= 1'b0;
			last_mem_req_addr <= '0;
		end else begin
			restart_valid <= next_restart_valid;
			restart_pc <= next_restart_pc;
			istream_stall <= next_istream_stall;
			mem_resp_valid <= next_mem_resp_valid;
			mem_resp_data <= next_mem_resp_data;
			last_istream_valid <= istream_valid;
			last_istream_pc <= istream_pc;
			last_istream_instr <= istream_instr;
			last_istream_page_fault <= istream_page_fault;
			last_mem_req_valid <= mem_req_valid;
			last_mem_req_addr <= mem_req_addr;
		end
	end

endmodule

`default_nettype wire

//--- icache.sv
`timescale 1ns/10ps
`default_nettype none

module icache import core_types_pkg::*; #(
	parameter int ICACHE_SETS = 16
) (
	input wire CLK,
	input wire nRST,

	// lookup and feedback
	input wire icache_req_valid,
	input wire [$clog2(ICACHE_SETS)-1:0] icache_req_index,
	output logic icache_resp_valid,
	output logic [PA_WIDTH-$clog2(ICACHE_SETS)-$clog2(FETCH_BYTES)-1:0] icache_resp_tag,
	output logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] icache_resp_data,
	input wire icache_resp_hit,
	input wire icache_resp_miss_valid,
	input wire [PA_WIDTH-$clog2(ICACHE_SETS)-$clog2(FETCH_BYTES)-1:0] icache_resp_miss_tag,

	// line refill
	output logic refill_req_valid,
	output logic [PA_WIDTH-1:0] refill_req_addr,
	input wire refill_resp_valid,
	input wire [WORD_WIDTH-1:0] refill_resp_data
);

	localparam int OFFSET_W = $clog2(FETCH_BYTES);
	localparam int INDEX_W = $clog2(ICACHE_SETS);
	localparam int TAG_W = PA_WIDTH - INDEX_W - OFFSET_W;
	localparam int WORD_W = $clog2(LINE_WORDS);

	logic [ICACHE_SETS-1:0] line_valid;
	logic [TAG_W-1:0] tag_arr [ICACHE_SETS];
	logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] data_arr [ICACHE_SETS];

	logic lookup_live;
	logic [INDEX_W-1:0] lookup_index;
	logic refill_busy;
	logic [INDEX_W-1:0] refill_index;
	logic [TAG_W-1:0] refill_tag;
	logic [WORD_W-1:0] refill_word;
	logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] refill_buf;
	logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] fill_line;
	logic miss_accept;
	logic last_word;

	// a conflicting hit drops the miss
	assign miss_accept = lookup_live & icache_resp_miss_valid & ~icache_resp_hit & ~refill_busy;
	assign last_word = refill_resp_valid && (refill_word == WORD_W'(LINE_WORDS - 1));

	always_comb begin
		fill_line = refill_buf;
		fill_line[refill_word] = refill_resp_data;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			line_valid <= '0;
			icache_resp_valid <= 1'b0;
			lookup_live <= 1'b0;
			refill_busy <= 1'b0;
			refill_req_valid <= 1'b0;
			refill_word <= '0;
		end else begin
			// no responses while a refill runs
			lookup_live <= icache_req_valid & ~refill_busy;
			icache_resp_valid <= icache_req_valid & ~refill_busy & line_valid[icache_req_index];
			refill_req_valid <= miss_accept | (refill_resp_valid & ~last_word);
			if (miss_accept) begin
				refill_busy <= 1'b1;
				refill_word <= '0;
			end else if (refill_resp_valid) begin
				refill_word <= refill_word + WORD_W'(1);
				if (last_word) begin
					refill_busy <= 1'b0;
					line_valid[refill_index] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		lookup_index <= icache_req_index;
		icache_resp_tag <= tag_arr[icache_req_index];
		icache_resp_data <= data_arr[icache_req_index];
		if (miss_accept) begin
			refill_index <= lookup_index;
			refill_tag <= icache_resp_miss_tag;
			refill_req_addr <= {icache_resp_miss_tag, lookup_index, {OFFSET_W{1'b0}}};
		end else if (refill_resp_valid) begin
			refill_buf[refill_word] <= refill_resp_data;
			refill_req_addr <= {refill_tag, refill_index, refill_word + WORD_W'(1), 2'b00};
		end
		// tag and data land together on the last word
		if (last_word) begin
			tag_arr[refill_index] <= refill_tag;
			data_arr[refill_index] <= fill_line;
		end
	end

endmodule

`default_nettype wire

//--- itlb.sv
`timescale 1ns/10ps
`default_nettype none

module itlb import core_types_pkg::*; #(
	parameter int ITLB_ENTRIES = 4
) (
	input wire CLK,
	input wire nRST,

	// lookup
	input wire itlb_req_valid,
	input wire [VPN_WIDTH-1:0] itlb_req_vpn,
	output logic itlb_resp_valid,
	output logic itlb_resp_miss,
	output logic [PPN_WIDTH-1:0] itlb_resp_ppn,
	output logic itlb_resp_page_fault,

	// page-table walk
	output logic walk_req_valid,
	output logic [PA_WIDTH-1:0] walk_req_addr,
	input wire walk_resp_valid,
	input wire [WORD_WIDTH-1:0] walk_resp_data
);

	localparam int VICTIM_W = (ITLB_ENTRIES > 1) ? $clog2(ITLB_ENTRIES) : 1;

	logic [ITLB_ENTRIES-1:0] entry_valid;
	logic [VPN_WIDTH-1:0] entry_vpn [ITLB_ENTRIES];
	logic [PPN_WIDTH-1:0] entry_ppn [ITLB_ENTRIES];
	logic [VICTIM_W-1:0] victim;

	logic walking;
	logic [VPN_WIDTH-1:0] walk_vpn;
	logic fault_valid;
	logic [VPN_WIDTH-1:0] fault_vpn;

	logic hit_any;
	logic [PPN_WIDTH-1:0] hit_ppn;
	logic high_fault;
	logic fault_hit;
	logic start_walk;
	logic fill;

	always_comb begin
		hit_any = 1'b0;
		hit_ppn = '0;
		for (int i = 0; i < ITLB_ENTRIES; i++) begin
			if (entry_valid[i] && entry_vpn[i] == itlb_req_vpn) begin
				hit_any = 1'b1;
				hit_ppn = entry_ppn[i];
			end
		end
	end

	// vpn beyond the table never walks
	assign high_fault = |itlb_req_vpn[VPN_WIDTH-1:PT_INDEX_WIDTH];
	// invalid pte seen by the last walk
	assign fault_hit = fault_valid && (fault_vpn == itlb_req_vpn);
	assign start_walk = itlb_req_valid & ~high_fault & ~walking & ~hit_any & ~fault_hit;
	assign fill = walk_resp_valid & walk_resp_data[PTE_VALID_BIT];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			itlb_resp_valid <= 1'b0;
			itlb_resp_miss <= 1'b0;
			itlb_resp_page_fault <= 1'b0;
			walk_req_valid <= 1'b0;
			walking <= 1'b0;
			fault_valid <= 1'b0;
			entry_valid <= '0;
			victim <= '0;
		end else begin
			itlb_resp_valid <= itlb_req_valid & ~start_walk & (high_fault | ~walking);
			itlb_resp_miss <= itlb_req_valid & ~high_fault & (walking | start_walk);
			itlb_resp_page_fault <= high_fault | ~hit_any;
			walk_req_valid <= start_walk;
			if (start_walk) begin
				walking <= 1'b1;
				fault_valid <= 1'b0;
			end else if (itlb_req_valid && !high_fault && !walking && !hit_any) begin
				// fault consumed by the replayed lookup
				fault_valid <= 1'b0;
			end
			if (walk_resp_valid) begin
				walking <= 1'b0;
				fault_valid <= ~walk_resp_data[PTE_VALID_BIT];
			end
			if (fill) begin
				entry_valid[victim] <= 1'b1;
				victim <= (victim == VICTIM_W'(ITLB_ENTRIES - 1)) ? '0 : victim + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (itlb_req_valid) begin
			itlb_resp_ppn <= hit_ppn;
		end
		if (start_walk) begin
			walk_vpn <= itlb_req_vpn;
			walk_req_addr <= PT_BASE + PA_WIDTH'({itlb_req_vpn[PT_INDEX_WIDTH-1:0], 2'b00});
		end
		if (walk_resp_valid) begin
			fault_vpn <= walk_vpn;
		end
		if (fill) begin
			entry_vpn[victim] <= walk_vpn;
			entry_ppn[victim] <= walk_resp_data[PPN_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter import core_types_pkg::*; (
	input wire CLK,
	input wire nRST,

	// requesters
	input wire walk_req_valid,
	input wire [PA_WIDTH-1:0] walk_req_addr,
	input wire refill_req_valid,
	input wire [PA_WIDTH-1:0] refill_req_addr,
	output logic walk_resp_valid,
	output logic refill_resp_valid,
	output logic [WORD_WIDTH-1:0] resp_data,

	// backing memory
	output logic mem_req_valid,
	output logic [PA_WIDTH-1:0] mem_req_addr,
	input wire mem_resp_valid,
	input wire [WORD_WIDTH-1:0] mem_resp_data
);

	logic walk_pend;
	logic refill_pend;
	logic [PA_WIDTH-1:0] walk_addr_q;
	logic [PA_WIDTH-1:0] refill_addr_q;
	logic busy;
	logic owner_refill;
	logic grant_walk;
	logic grant_refill;
	logic resp_done;

	// walker wins over refill
	assign grant_walk = ~busy & walk_pend;
	assign grant_refill = ~busy & ~walk_pend & refill_pend;
	assign resp_done = busy & mem_resp_valid;

	assign walk_resp_valid = resp_done & ~owner_refill;
	assign refill_resp_valid = resp_done & owner_refill;
	assign resp_data = mem_resp_data;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			walk_pend <= 1'b0;
			refill_pend <= 1'b0;
			busy <= 1'b0;
			owner_refill <= 1'b0;
			mem_req_valid <= 1'b0;
		end else begin
			mem_req_valid <= grant_walk | grant_refill;
			if (grant_walk | grant_refill) begin
				busy <= 1'b1;
				owner_refill <= grant_refill;
			end else if (resp_done) begin
				busy <= 1'b0;
			end
			walk_pend <= walk_req_valid | (walk_pend & ~grant_walk);
			refill_pend <= refill_req_valid | (refill_pend & ~grant_refill);
		end
	end

	always_ff @(posedge CLK) begin
		if (walk_req_valid) begin
			walk_addr_q <= walk_req_addr;
		end
		if (refill_req_valid) begin
			refill_addr_q <= refill_req_addr;
		end
		if (grant_walk | grant_refill) begin
			mem_req_addr <= grant_walk ? walk_addr_q : refill_addr_q;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the fetch front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module tb_fetch_unit_wrapper -Mdir obj_dir -f fetch_unit_wrapper.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_fetch_unit_wrapper
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit 1
fi
exit 0

//--- tb_fetch_unit_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_unit_wrapper import core_types_pkg::*; ();

	localparam logic [31:0] SEED = 32'h62c3_b9de;
	localparam int RUN_BLOCKS = 40;
	// consecutive lines that share the 16-set cache without eviction
	localparam int WARM_BLOCKS = 15;

	logic CLK;
	logic nRST;
	logic next_restart_valid;
	logic [VA_WIDTH-1:0] next_restart_pc;
	logic next_istream_stall;
	logic next_mem_resp_valid;
	logic [WORD_WIDTH-1:0] next_mem_resp_data;
	logic last_istream_valid;
	logic [VA_WIDTH-1:0] last_istream_pc;
	logic [FETCH_PARCELS-1:0][15:0] last_istream_instr;
	logic last_istream_page_fault;
	logic last_mem_req_valid;
	logic [PA_WIDTH-1:0] last_mem_req_addr;

	// reference state
	integer seed;
	string test_name;
	logic stream_on;
	logic expect_fault;
	logic fault_seen;
	logic restarted;
	logic [VA_WIDTH-1:0] expect_pc;
	int block_count;
	logic mem_busy;
	logic [PA_WIDTH-1:0] refill_addr;
	logic addr_ok;
	int stall_age;

	fetch_unit_wrapper #(.ITLB_ENTRIES(4), .ICACHE_SETS(16)) dut (.*);

	fetch_mem_model #(.SEED(SEED)) backing_mem (
		.CLK(CLK),
		.req_valid(last_mem_req_valid),
		.req_addr(last_mem_req_addr),
		.resp_valid(next_mem_resp_valid),
		.resp_data(next_mem_resp_data)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#5 CLK = ~CLK;
		end
	end

	// --------------------
	// error reporting
	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		stop_run();
	endtask

	task automatic report_mismatch(input string what, input logic [127:0] exp,
			input logic [127:0] act);
		$display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what, exp, act);
		stop_run();
	endtask

	// --------------------
	// reference model
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic logic [VA_WIDTH-1:0] mapped_pc(input int min_offset);
		logic [VA_WIDTH-1:0] vpn;
		logic [VA_WIDTH-1:0] offset;
		// vpn 47 left out, so a run may cross into the next page
		vpn = VA_WIDTH'(rand_below(47));
		offset = VA_WIDTH'(min_offset + rand_below(4096 - min_offset));
		return (vpn << PAGE_OFFSET_WIDTH) | offset;
	endfunction

	function automatic logic [WORD_WIDTH-1:0] mem_word(input logic [PA_WIDTH-1:0] pa);
		int entry;
		if (pa < PT_BASE) begin
			return 32'(pa) * 32'h9e37_79b9;
		end
		entry = int'(pa - PT_BASE) / 4;
		if (entry < 48) begin
			return 32'h8000_0000 | 32'(entry % 16);
		end
		return '0;
	endfunction

	function automatic logic [127:0] expected_block(input logic [VA_WIDTH-1:0] pc);
		logic [VPN_WIDTH-1:0] vpn;
		logic [PA_WIDTH-1:0] line_pa;
		logic [127:0] blk;
		vpn = pc[VA_WIDTH-1:PAGE_OFFSET_WIDTH];
		// mapped pages have ppn = vpn mod 16
		line_pa = {PPN_WIDTH'(vpn % 16), pc[PAGE_OFFSET_WIDTH-1:4], 4'h0};
		for (int i = 0; i < LINE_WORDS; i++) begin
			blk[32*i +: 32] = mem_word(line_pa + PA_WIDTH'(4 * i));
		end
		return blk;
	endfunction

	// --------------------
	// monitor, sampled on the falling edge
	always @(negedge CLK) begin
		if (next_mem_resp_valid) begin
			mem_busy = 1'b0;
		end
		if (last_mem_req_valid) begin
			assert (restarted) else report_error("memory request before the first restart");
			assert (!mem_busy) else report_error("memory request while another is unanswered");
			if (last_mem_req_addr >= PT_BASE) begin
				addr_ok = (last_mem_req_addr[1:0] == 2'b00);
			end else if (last_mem_req_addr[3:0] == 4'h0) begin
				addr_ok = 1'b1;
				refill_addr = last_mem_req_addr;
			end else begin
				// refill words come in increasing order
				addr_ok = (last_mem_req_addr == refill_addr + 16'd4);
				refill_addr = last_mem_req_addr;
			end
			assert (addr_ok) else report_error("memory request outside table and refill lines");
			mem_busy = 1'b1;
		end
		if (next_istream_stall) begin
			stall_age = stall_age + 1;
		end else begin
			stall_age = 0;
		end
		if (last_istream_valid) begin
			assert (stall_age < 3) else report_error("block emitted after the stall took hold");
			assert (stream_on) else report_error("block emitted while fetch should be idle");
			assert (last_istream_pc == expect_pc)
				else report_mismatch("pc", 128'(expect_pc), 128'(last_istream_pc));
			if (expect_fault) begin
				assert (last_istream_page_fault)
					else report_mismatch("fault flag", 128'(1), 128'(0));
				assert (last_istream_instr == '0)
					else report_mismatch("fault parcels", 128'(0), last_istream_instr);
				stream_on = 1'b0;
				fault_seen = 1'b1;
			end else begin
				assert (!last_istream_page_fault)
					else report_mismatch("fault flag", 128'(0), 128'(1));
				assert (last_istream_instr == expected_block(expect_pc))
					else report_mismatch("parcels", expected_block(expect_pc),
						last_istream_instr);
				expect_pc = expect_pc + VA_WIDTH'(FETCH_BYTES);
				block_count = block_count + 1;
			end
		end
	end

	// --------------------
	// stimulus tasks, each ends just after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic restart_fetch(input logic [VA_WIDTH-1:0] pc, input logic fault);
		restarted = 1'b1;
		next_restart_valid = 1'b1;
		next_restart_pc = pc;
		@(posedge CLK);
		#1;
		next_restart_valid = 1'b0;
		@(posedge CLK);
		#1;
		// old stream has drained by now
		expect_pc = {pc[VA_WIDTH-1:4], 4'h0};
		expect_fault = fault;
		fault_seen = 1'b0;
		stream_on = 1'b1;
	endtask

	task automatic wait_blocks(input int n);
		int target;
		int cycles;
		target = block_count + n;
		cycles = 0;
		while (block_count < target) begin
			@(posedge CLK);
			#1;
			cycles++;
			if (cycles > 300 + 120 * n) report_error("timeout waiting for fetch blocks");
		end
	endtask

	task automatic wait_refill();
		int cycles;
		cycles = 0;
		while (!(last_mem_req_valid && last_mem_req_addr < PT_BASE)) begin
			@(posedge CLK);
			#1;
			cycles++;
			if (cycles > 500) report_error("no line refill request seen");
		end
	endtask

	task automatic wait_fault();
		int cycles;
		cycles = 0;
		while (!fault_seen) begin
			@(posedge CLK);
			#1;
			cycles++;
			if (cycles > 400) report_error("no page-fault block after restart");
		end
	endtask

	// --------------------
	// test sequence
	initial begin
		logic [VA_WIDTH-1:0] pc;
		seed = SEED;
		nRST = 1'b0;
		next_restart_valid = 1'b0;
		next_restart_pc = '0;
		next_istream_stall = 1'b0;
		test_name = "reset";
		stream_on = 1'b0;
		expect_fault = 1'b0;
		fault_seen = 1'b0;
		restarted = 1'b0;
		expect_pc = '0;
		block_count = 0;
		mem_busy = 1'b0;
		refill_addr = '0;
		addr_ok = 1'b1;
		stall_age = 0;
		repeat (16) @(posedge CLK);
		#1;
		nRST = 1'b1;
		idle_cycles(20);

		// start near a page end so the run crosses it
		test_name = "sequential run";
		restart_fetch(mapped_pc('he00), 1'b0);
		wait_blocks(RUN_BLOCKS);

		test_name = "mid-stream restart";
		for (int i = 0; i < 6; i++) begin
			if (i % 2 == 1) begin
				wait_refill();
			end else begin
				idle_cycles(1 + rand_below(20));
			end
			restart_fetch(mapped_pc(0), 1'b0);
			wait_blocks(4 + rand_below(8));
		end

		test_name = "unmapped page";
		pc = (32'(48 + rand_below(16)) << PAGE_OFFSET_WIDTH) | 32'(rand_below(4096));
		restart_fetch(pc, 1'b1);
		wait_fault();
		idle_cycles(50);

		test_name = "vpn beyond table";
		pc = $random(seed);
		pc[18] = 1'b1;
		restart_fetch(pc, 1'b1);
		wait_fault();
		idle_cycles(50);

		test_name = "stall";
		for (int i = 0; i < 3; i++) begin
			pc = mapped_pc(0);
			// first pass fills the lines, second pass streams one block per cycle
			restart_fetch(pc, 1'b0);
			wait_blocks(WARM_BLOCKS);
			restart_fetch(pc, 1'b0);
			wait_blocks(5);
			next_istream_stall = 1'b1;
			idle_cycles(4 + rand_below(10));
			next_istream_stall = 1'b0;
			wait_blocks(10);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
